// ==== Bender.yml ====
package:
  name: cache_memory

sources:
  - cache_mem_pkg.sv
  - cache_sp_ram.sv
  - cache_access_ctrl.sv
  - cache_tag_array.sv
  - cache_data_array.sv
  - cache_result_select.sv
  - cache_memory_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_cache_memory.sv

// ==== cache_access_ctrl.sv ====
`default_nettype none
`timescale 1ns/100ps

module cache_access_ctrl #(
  parameter int WAYS = 2
) (
  input  wire logic                    clk_i,
  input  wire logic                    rst_ni,
  // lookup
  input  wire logic                    lookup_i,
  input  wire cache_mem_pkg::idx_t     lookup_idx_i,
  input  wire cache_mem_pkg::tag_t     lookup_tag_i,
  input  wire logic [WAYS-1:0]         victim_way_i,
  // line fill from bus side
  input  wire logic                    fill_i,
  input  wire cache_mem_pkg::idx_t     fill_idx_i,
  input  wire cache_mem_pkg::tag_t     fill_tag_i,
  input  wire cache_mem_pkg::line_t    fill_line_i,
  input  wire logic                    fill_dirty_i,
  input  wire logic [WAYS-1:0]         fill_way_i,
  // write buffer word write
  input  wire logic                    wr_i,
  input  wire cache_mem_pkg::idx_t     wr_idx_i,
  input  wire cache_mem_pkg::offs_t    wr_offs_i,
  input  wire cache_mem_pkg::word_be_t wr_be_i,
  input  wire cache_mem_pkg::word_t    wr_data_i,
  input  wire logic [WAYS-1:0]         wr_ways_i,
  // to the arrays
  output cache_mem_pkg::idx_t          ram_idx_o,
  output logic [WAYS-1:0]              tag_we_o,
  output cache_mem_pkg::tag_t          tag_din_o,
  output logic [WAYS-1:0]              dirty_we_o,
  output logic                         dirty_din_o,
  output logic [WAYS-1:0]              dat_we_o,
  output cache_mem_pkg::line_be_t      dat_be_o,
  output cache_mem_pkg::line_t         dat_din_o,
  // lookup context, lined up with ram output
  output logic                         rd_valid_o,
  output cache_mem_pkg::tag_t          cmp_tag_o,
  output logic [WAYS-1:0]              victim_o
);

  localparam int WORD_BYTES = cache_mem_pkg::XLEN / 8;

  logic [WAYS-1:0] line_we; // way written by fill or write

  ////////////////////
  // port arbitration
  ////////////////////

  assign ram_idx_o = fill_i ? fill_idx_i : (wr_i ? wr_idx_i : lookup_idx_i); // fill wins

  assign tag_we_o  = {WAYS{fill_i}} & fill_way_i; // tag only changes on a fill
  assign tag_din_o = fill_tag_i;

  assign line_we     = fill_i ? fill_way_i : ({WAYS{wr_i}} & wr_ways_i);
  assign dirty_we_o  = line_we;
  assign dirty_din_o = fill_i ? fill_dirty_i : 1'b1; // a core write always dirties
  assign dat_we_o    = line_we;

  // word write is replicated, byte enables pick the slot
  assign dat_din_o = fill_i ? fill_line_i
                            : {cache_mem_pkg::WORDS_PER_LINE{wr_data_i}};

  always_comb
  begin
    dat_be_o = '0;
    if (fill_i)
    begin
      dat_be_o = '1; // whole line
    end
    else
    begin
      for (int w = 0; w < cache_mem_pkg::WORDS_PER_LINE; w++)
      begin
        if (cache_mem_pkg::offs_t'(w) == wr_offs_i)
        begin
          dat_be_o[w*WORD_BYTES +: WORD_BYTES] = wr_be_i;
        end
      end
    end
  end

  ////////////////////
  // lookup delay
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      rd_valid_o <= 1'b0;
    end
    else
    begin
      rd_valid_o <= lookup_i;
    end
  end

  always_ff @(posedge clk_i)
  begin
    cmp_tag_o <= lookup_tag_i; // compared next cycle
    victim_o  <= victim_way_i;
  end

  // no bypass path, so ops must not overlap
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0({lookup_i, fill_i, wr_i}))
    else $error("lookup, fill and write strobes overlap");

  assert property (@(posedge clk_i) disable iff (!rst_ni) fill_i |-> $onehot(fill_way_i))
    else $error("fill way not one-hot");

  assert property (@(posedge clk_i) disable iff (!rst_ni) wr_i |-> $onehot(wr_ways_i))
    else $error("write way not one-hot");

  assert property (@(posedge clk_i) disable iff (!rst_ni) lookup_i |-> $onehot(victim_way_i))
    else $error("victim way not one-hot");

endmodule

`default_nettype wire

// ==== cache_data_array.sv ====
`default_nettype none
`timescale 1ns/100ps

module cache_data_array #(
  parameter int WAYS = 2
) (
  input  wire logic                        clk_i,
  input  wire cache_mem_pkg::idx_t         ram_idx_i,
  input  wire logic [WAYS-1:0]             dat_we_i,
  input  wire cache_mem_pkg::line_be_t     dat_be_i,
  input  wire cache_mem_pkg::line_t        dat_din_i,
  output cache_mem_pkg::line_t [WAYS-1:0]  way_line_o
);

  localparam int LINE_BITS = cache_mem_pkg::LINE_BYTES * 8;

  ////////////////////
  // line rams
  ////////////////////

  // shared index, enables and data, own write enable per way
  for (genvar w = 0; w < WAYS; w++)
  begin : gen_way
    cache_sp_ram #(
      .ABITS  ( cache_mem_pkg::IDX_BITS ),
      .DBITS  ( LINE_BITS               )
    ) i_data_ram (
      .clk_i  ( clk_i                   ),
      .addr_i ( ram_idx_i               ),
      .we_i   ( dat_we_i[w]             ), // only the chosen way
      .be_i   ( dat_be_i                ),
      .din_i  ( dat_din_i               ),
      .dout_o ( way_line_o[w]           )  // valid one cycle after the index
    );
  end

endmodule

`default_nettype wire

// ==== cache_mem_pkg.sv ====
`default_nettype none

package cache_mem_pkg;

  ////////////////////
  // geometry
  ////////////////////

  localparam int SETS           = 16;                     // sets per way
  localparam int IDX_BITS       = $clog2(SETS);           // set index width
  localparam int LINE_BYTES     = 8;                      // bytes per line
  localparam int XLEN           = 32;                     // core word width, also address width
  localparam int WORDS_PER_LINE = (LINE_BYTES * 8) / XLEN;
  localparam int OFFS_BITS      = $clog2(WORDS_PER_LINE); // word select within a line

  // address minus index minus byte offset in line
  localparam int TAG_BITS       = XLEN - IDX_BITS - $clog2(LINE_BYTES);

  localparam int DEFAULT_WAYS   = 2;

  ////////////////////
  // types
  ////////////////////

  typedef logic [IDX_BITS-1:0]       idx_t;     // set index
  typedef logic [TAG_BITS-1:0]       tag_t;     // address tag
  typedef logic [LINE_BYTES*8-1:0]   line_t;    // one full line
  typedef logic [LINE_BYTES-1:0]     line_be_t; // byte enables over a line
  typedef logic [XLEN-1:0]           word_t;    // core word
  typedef logic [XLEN/8-1:0]         word_be_t; // byte enables over a word
  typedef logic [OFFS_BITS-1:0]      offs_t;    // word offset in line

endpackage

`default_nettype wire

// ==== cache_memory_top.sv ====
`default_nettype none
`timescale 1ns/100ps

module cache_memory_top #(
  parameter int WAYS = cache_mem_pkg::DEFAULT_WAYS
) (
  input  wire logic                    clk_i,
  input  wire logic                    rst_ni,
  // lookup
  input  wire logic                    lookup_i,
  input  wire cache_mem_pkg::idx_t     lookup_idx_i,
  input  wire cache_mem_pkg::tag_t     lookup_tag_i,
  input  wire logic [WAYS-1:0]         victim_way_i,
  // fill
  input  wire logic                    fill_i,
  input  wire cache_mem_pkg::idx_t     fill_idx_i,
  input  wire cache_mem_pkg::tag_t     fill_tag_i,
  input  wire cache_mem_pkg::line_t    fill_line_i,
  input  wire logic                    fill_dirty_i,
  input  wire logic [WAYS-1:0]         fill_way_i,
  // write buffer
  input  wire logic                    wr_i,
  input  wire cache_mem_pkg::idx_t     wr_idx_i,
  input  wire cache_mem_pkg::offs_t    wr_offs_i,
  input  wire cache_mem_pkg::word_be_t wr_be_i,
  input  wire cache_mem_pkg::word_t    wr_data_i,
  input  wire logic [WAYS-1:0]         wr_ways_i,
  input  wire logic                    flush_i,
  // response
  output logic                         rsp_valid_o,
  output logic                         hit_o,
  output logic [WAYS-1:0]              ways_hit_o,
  output logic                         dirty_o,
  output cache_mem_pkg::line_t         line_o,
  output cache_mem_pkg::tag_t          evict_tag_o,
  output cache_mem_pkg::line_t         evict_line_o,
  output logic                         evict_dirty_o
);

  ////////////////////
  // internal nets
  ////////////////////

  cache_mem_pkg::idx_t             ram_idx;
  logic [WAYS-1:0]                 tag_we;
  cache_mem_pkg::tag_t             tag_din;
  logic [WAYS-1:0]                 dirty_we;
  logic                            dirty_din;
  logic [WAYS-1:0]                 dat_we;
  cache_mem_pkg::line_be_t         dat_be;
  cache_mem_pkg::line_t            dat_din;
  logic                            rd_valid;  // lookup, one cycle late
  cache_mem_pkg::tag_t             cmp_tag;
  logic [WAYS-1:0]                 victim_q;
  logic [WAYS-1:0]                 way_hit;
  logic [WAYS-1:0]                 way_dirty;
  cache_mem_pkg::tag_t  [WAYS-1:0] way_tag;
  cache_mem_pkg::line_t [WAYS-1:0] way_line;

  cache_access_ctrl #(
    .WAYS         ( WAYS         )
  ) i_access_ctrl (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .lookup_i     ( lookup_i     ),
    .lookup_idx_i ( lookup_idx_i ),
    .lookup_tag_i ( lookup_tag_i ),
    .victim_way_i ( victim_way_i ),
    .fill_i       ( fill_i       ),
    .fill_idx_i   ( fill_idx_i   ),
    .fill_tag_i   ( fill_tag_i   ),
    .fill_line_i  ( fill_line_i  ),
    .fill_dirty_i ( fill_dirty_i ),
    .fill_way_i   ( fill_way_i   ),
    .wr_i         ( wr_i         ),
    .wr_idx_i     ( wr_idx_i     ),
    .wr_offs_i    ( wr_offs_i    ),
    .wr_be_i      ( wr_be_i      ),
    .wr_data_i    ( wr_data_i    ),
    .wr_ways_i    ( wr_ways_i    ),
    .ram_idx_o    ( ram_idx      ),
    .tag_we_o     ( tag_we       ),
    .tag_din_o    ( tag_din      ),
    .dirty_we_o   ( dirty_we     ),
    .dirty_din_o  ( dirty_din    ),
    .dat_we_o     ( dat_we       ),
    .dat_be_o     ( dat_be       ),
    .dat_din_o    ( dat_din      ),
    .rd_valid_o   ( rd_valid     ),
    .cmp_tag_o    ( cmp_tag      ),
    .victim_o     ( victim_q     )
  );

  cache_tag_array #(
    .WAYS        ( WAYS      )
  ) i_tag_array (
    .clk_i       ( clk_i     ),
    .rst_ni      ( rst_ni    ),
    .flush_i     ( flush_i   ),
    .ram_idx_i   ( ram_idx   ),
    .tag_we_i    ( tag_we    ),
    .tag_din_i   ( tag_din   ),
    .dirty_we_i  ( dirty_we  ),
    .dirty_din_i ( dirty_din ),
    .cmp_tag_i   ( cmp_tag   ),
    .way_hit_o   ( way_hit   ),
    .way_dirty_o ( way_dirty ),
    .way_tag_o   ( way_tag   )
  );

  cache_data_array #(
    .WAYS       ( WAYS     )
  ) i_data_array (
    .clk_i      ( clk_i    ),
    .ram_idx_i  ( ram_idx  ),
    .dat_we_i   ( dat_we   ),
    .dat_be_i   ( dat_be   ),
    .dat_din_i  ( dat_din  ),
    .way_line_o ( way_line )
  );

  cache_result_select #(
    .WAYS          ( WAYS          )
  ) i_result_select (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .rd_valid_i    ( rd_valid      ),
    .victim_i      ( victim_q      ),
    .way_hit_i     ( way_hit       ),
    .way_dirty_i   ( way_dirty     ),
    .way_tag_i     ( way_tag       ),
    .way_line_i    ( way_line      ),
    .rsp_valid_o   ( rsp_valid_o   ),
    .hit_o         ( hit_o         ),
    .ways_hit_o    ( ways_hit_o    ),
    .dirty_o       ( dirty_o       ),
    .line_o        ( line_o        ),
    .evict_tag_o   ( evict_tag_o   ),
    .evict_line_o  ( evict_line_o  ),
    .evict_dirty_o ( evict_dirty_o )
  );

endmodule

`default_nettype wire

// ==== cache_result_select.sv ====
`default_nettype none
`timescale 1ns/100ps

module cache_result_select #(
  parameter int WAYS = 2
) (
  input  wire logic                             clk_i,
  input  wire logic                             rst_ni,
  input  wire logic                             rd_valid_i,
  input  wire logic [WAYS-1:0]                  victim_i,
  input  wire logic [WAYS-1:0]                  way_hit_i,
  input  wire logic [WAYS-1:0]                  way_dirty_i,
  input  wire cache_mem_pkg::tag_t  [WAYS-1:0]  way_tag_i,
  input  wire cache_mem_pkg::line_t [WAYS-1:0]  way_line_i,
  output logic                                  rsp_valid_o,
  output logic                                  hit_o,
  output logic [WAYS-1:0]                       ways_hit_o,
  output logic                                  dirty_o,
  output cache_mem_pkg::line_t                  line_o,
  output cache_mem_pkg::tag_t                   evict_tag_o,
  output cache_mem_pkg::line_t                  evict_line_o,
  output logic                                  evict_dirty_o
);

  localparam int LINE_BITS = cache_mem_pkg::LINE_BYTES * 8;
  localparam int TAG_BITS  = cache_mem_pkg::TAG_BITS;

  cache_mem_pkg::line_t hit_line;    // and-or mux over hit ways
  cache_mem_pkg::tag_t  evict_tag;   // victim way fields
  cache_mem_pkg::line_t evict_line;
  logic                 evict_dirty;

  ////////////////////
  // way muxes
  ////////////////////

  // one-hot selects, so a plain and-or is enough
  always_comb
  begin
    hit_line    = '0;
    evict_tag   = '0;
    evict_line  = '0;
    evict_dirty = 1'b0;
    for (int w = 0; w < WAYS; w++)
    begin
      hit_line    |= way_line_i[w] & {LINE_BITS{way_hit_i[w]}};
      evict_tag   |= way_tag_i[w]  & {TAG_BITS{victim_i[w]}};
      evict_line  |= way_line_i[w] & {LINE_BITS{victim_i[w]}};
      evict_dirty |= way_dirty_i[w] & victim_i[w];
    end
  end

  ////////////////////
  // output stage
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      rsp_valid_o <= 1'b0;
    end
    else
    begin
      rsp_valid_o <= rd_valid_i; // single cycle pulse
    end
  end

  // results hold until the next lookup
  always_ff @(posedge clk_i)
  begin
    if (rd_valid_i)
    begin
      hit_o         <= |way_hit_i;
      ways_hit_o    <= way_hit_i;
      dirty_o       <= |way_dirty_i; // any way of the set dirty
      line_o        <= hit_line;
      evict_tag_o   <= evict_tag;
      evict_line_o  <= evict_line;
      evict_dirty_o <= evict_dirty;
    end
  end

  // a tag may live in one way only
  assert property (@(posedge clk_i) disable iff (!rst_ni) rd_valid_i |-> $onehot0(way_hit_i))
    else $error("tag hits in more than one way");

endmodule

`default_nettype wire

// ==== cache_sp_ram.sv ====
`default_nettype none
`timescale 1ns/100ps

// single port sram model, sync read, byte masked write
module cache_sp_ram #(
  parameter int ABITS = 4,
  parameter int DBITS = 32
) (
  input  wire logic                   clk_i,
  input  wire logic [ABITS-1:0]       addr_i,
  input  wire logic                   we_i,
  input  wire logic [(DBITS+7)/8-1:0] be_i,   // last lane may be partial
  input  wire logic [DBITS-1:0]       din_i,
  output logic      [DBITS-1:0]       dout_o
);

  localparam int DEPTH = 2**ABITS;

  logic [DBITS-1:0] mem [DEPTH]; // storage array

  ////////////////////
  // access
  ////////////////////

  always_ff @(posedge clk_i)
  begin
    if (we_i)
    begin
      // bit loop so a partial top byte works too
      for (int b = 0; b < DBITS; b++)
      begin
        if (be_i[b/8])
        begin
          mem[addr_i][b] <= din_i[b];
        end
      end
    end
    dout_o <= mem[addr_i]; // read first, old data on a write
  end

endmodule

`default_nettype wire

// ==== cache_tag_array.sv ====
`default_nettype none
`timescale 1ns/100ps

module cache_tag_array #(
  parameter int WAYS = 2
) (
  input  wire logic                     clk_i,
  input  wire logic                     rst_ni,
  input  wire logic                     flush_i,
  input  wire cache_mem_pkg::idx_t      ram_idx_i,
  input  wire logic [WAYS-1:0]          tag_we_i,
  input  wire cache_mem_pkg::tag_t      tag_din_i,
  input  wire logic [WAYS-1:0]          dirty_we_i,
  input  wire logic                     dirty_din_i,
  input  wire cache_mem_pkg::tag_t      cmp_tag_i,
  output logic [WAYS-1:0]               way_hit_o,
  output logic [WAYS-1:0]               way_dirty_o,
  output cache_mem_pkg::tag_t [WAYS-1:0] way_tag_o
);

  localparam int TAG_BE_BITS = (cache_mem_pkg::TAG_BITS + 7) / 8;

  logic [WAYS-1:0][cache_mem_pkg::SETS-1:0] valid_q; // per way, per set
  logic [WAYS-1:0][cache_mem_pkg::SETS-1:0] dirty_q;
  cache_mem_pkg::idx_t                      rd_idx_q; // index of the ram output

  // follows the ram by one cycle
  always_ff @(posedge clk_i)
  begin
    rd_idx_q <= ram_idx_i;
  end

  for (genvar w = 0; w < WAYS; w++)
  begin : gen_way

    ////////////////////
    // tag ram
    ////////////////////

    cache_sp_ram #(
      .ABITS  ( cache_mem_pkg::IDX_BITS ),
      .DBITS  ( cache_mem_pkg::TAG_BITS )
    ) i_tag_ram (
      .clk_i  ( clk_i                   ),
      .addr_i ( ram_idx_i               ),
      .we_i   ( tag_we_i[w]             ),
      .be_i   ( {TAG_BE_BITS{1'b1}}     ), // tag always written whole
      .din_i  ( tag_din_i               ),
      .dout_o ( way_tag_o[w]            )
    );

    ////////////////////
    // valid and dirty
    ////////////////////

    always_ff @(posedge clk_i or negedge rst_ni)
    begin
      if (!rst_ni)
      begin
        valid_q[w] <= '0;
      end
      else if (flush_i)
      begin
        valid_q[w] <= '0; // all sets at once
      end
      else if (tag_we_i[w])
      begin
        valid_q[w][ram_idx_i] <= 1'b1; // fill
      end
    end

    always_ff @(posedge clk_i or negedge rst_ni)
    begin
      if (!rst_ni)
      begin
        dirty_q[w] <= '0;
      end
      else if (dirty_we_i[w])
      begin
        dirty_q[w][ram_idx_i] <= dirty_din_i; // fill or core write
      end
    end

    // compare with the delayed lookup tag
    assign way_hit_o[w]   = valid_q[w][rd_idx_q] & (way_tag_o[w] == cmp_tag_i);
    assign way_dirty_o[w] = valid_q[w][rd_idx_q] & dirty_q[w][rd_idx_q]; // stale dirty masked
  end

  // flush must not race a fill or write from the access side
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    flush_i |-> !(|{tag_we_i, dirty_we_i}))
    else $error("flush overlaps a fill or write");

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+.
cache_mem_pkg.sv
cache_sp_ram.sv
cache_access_ctrl.sv
cache_tag_array.sv
cache_data_array.sv
cache_result_select.sv
cache_memory_top.sv
tb_cache_memory.sv

// ==== tb_cache_tasks.svh ====
// reference model, indexed [way][set]
cache_mem_pkg::tag_t  m_tag   [WAYS][SETS];
cache_mem_pkg::line_t m_line  [WAYS][SETS];
logic                 m_valid [WAYS][SETS];
logic                 m_dirty [WAYS][SETS];
logic                 m_known [WAYS][SETS]; // tag and line ever written

////////////////////
// model
////////////////////

task automatic clear_model();
  for (int w = 0; w < WAYS; w++)
  begin
    for (int s = 0; s < SETS; s++)
    begin
      m_valid[w][s] = 1'b0;
      m_dirty[w][s] = 1'b0;
      m_known[w][s] = 1'b0;
    end
  end
endtask

// expected response from the model state at issue time
function automatic rsp_exp_t predict_rsp(input cache_mem_pkg::idx_t idx,
                                         input cache_mem_pkg::tag_t tag,
                                         input logic [WAYS-1:0] victim);
  rsp_exp_t e;
  e = '0;
  for (int w = 0; w < WAYS; w++)
  begin
    if (m_valid[w][idx] && m_tag[w][idx] == tag)
    begin
      e.ways[w] = 1'b1;
      e.line    = m_line[w][idx];
    end
    if (m_valid[w][idx] && m_dirty[w][idx])
    begin
      e.dirty = 1'b1; // any dirty way in the set
    end
    if (victim[w])
    begin
      e.ev_known = m_known[w][idx];
      e.ev_tag   = m_tag[w][idx];
      e.ev_line  = m_line[w][idx];
      e.ev_dirty = m_valid[w][idx] && m_dirty[w][idx];
    end
  end
  e.hit = |e.ways;
  return e;
endfunction

////////////////////
// stimulus
////////////////////

// one slot per cycle, driven just after the edge
task automatic next_slot();
  @(posedge clk);
  #0.5;
  lookup = 1'b0;
  fill   = 1'b0;
  wr     = 1'b0;
  flush  = 1'b0;
endtask

task automatic send_lookup(input cache_mem_pkg::idx_t idx, input cache_mem_pkg::tag_t tag,
                           input logic [WAYS-1:0] victim);
  next_slot();
  lookup     = 1'b1;
  lookup_idx = idx;
  lookup_tag = tag;
  victim_way = victim;
  exp_q.push_back(predict_rsp(idx, tag, victim));
endtask

task automatic load_line(input cache_mem_pkg::idx_t idx, input int way,
                         input cache_mem_pkg::tag_t tag, input cache_mem_pkg::line_t data,
                         input logic dirty);
  next_slot();
  fill           = 1'b1;
  fill_idx       = idx;
  fill_tag       = tag;
  fill_line      = data;
  fill_dirty     = dirty;
  fill_way       = '0;
  fill_way[way]  = 1'b1;
  m_tag[way][idx]   = tag;
  m_line[way][idx]  = data;
  m_valid[way][idx] = 1'b1;
  m_dirty[way][idx] = dirty;
  m_known[way][idx] = 1'b1;
endtask

// word write into a way that hits
task automatic write_word(input cache_mem_pkg::idx_t idx, input cache_mem_pkg::offs_t offs,
                          input cache_mem_pkg::word_be_t be, input cache_mem_pkg::word_t data,
                          input int way);
  int base;
  next_slot();
  wr           = 1'b1;
  wr_idx       = idx;
  wr_offs      = offs;
  wr_be        = be;
  wr_data      = data;
  wr_ways      = '0;
  wr_ways[way] = 1'b1;
  base = int'(offs) * cache_mem_pkg::XLEN;
  for (int b = 0; b < cache_mem_pkg::XLEN / 8; b++)
  begin
    if (be[b])
    begin
      m_line[way][idx][base + b*8 +: 8] = data[b*8 +: 8]; // enabled bytes only
    end
  end
  m_dirty[way][idx] = 1'b1;
endtask

task automatic flush_all();
  next_slot();
  flush = 1'b1;
  for (int w = 0; w < WAYS; w++)
  begin
    for (int s = 0; s < SETS; s++)
    begin
      m_valid[w][s] = 1'b0; // tags and lines stay in the rams
    end
  end
endtask

// wait out every outstanding response
task automatic drain_rsp();
  next_slot();
  while (exp_q.size() != 0 || rsp_valid)
  begin
    @(posedge clk);
  end
  repeat (2) @(posedge clk);
endtask

// ==== tb_cache_memory.sv ====
`default_nettype none
`timescale 1ns/100ps

module tb_cache_memory;

  localparam int WAYS     = 2;
  localparam int SETS     = cache_mem_pkg::SETS;
  localparam int N_RANDOM = 300;
  // 16 reset + about 60 directed + 300 random slots with drains, x10 margin
  localparam int TIMEOUT_CYCLES = 4000;

  // expected response of one lookup
  typedef struct packed {
    logic                 hit;
    logic [WAYS-1:0]      ways;
    logic                 dirty;
    cache_mem_pkg::line_t line;
    logic                 ev_known; // victim way was ever filled
    cache_mem_pkg::tag_t  ev_tag;
    cache_mem_pkg::line_t ev_line;
    logic                 ev_dirty;
  } rsp_exp_t;

  logic                    clk = 1'b0;
  logic                    rst_n;
  logic                    lookup;
  cache_mem_pkg::idx_t     lookup_idx;
  cache_mem_pkg::tag_t     lookup_tag;
  logic [WAYS-1:0]         victim_way;
  logic                    fill;
  cache_mem_pkg::idx_t     fill_idx;
  cache_mem_pkg::tag_t     fill_tag;
  cache_mem_pkg::line_t    fill_line;
  logic                    fill_dirty;
  logic [WAYS-1:0]         fill_way;
  logic                    wr;
  cache_mem_pkg::idx_t     wr_idx;
  cache_mem_pkg::offs_t    wr_offs;
  cache_mem_pkg::word_be_t wr_be;
  cache_mem_pkg::word_t    wr_data;
  logic [WAYS-1:0]         wr_ways;
  logic                    flush;
  logic                    rsp_valid;
  logic                    rsp_hit;
  logic [WAYS-1:0]         rsp_ways;
  logic                    rsp_dirty;
  cache_mem_pkg::line_t    rsp_line;
  cache_mem_pkg::tag_t     ev_tag;
  cache_mem_pkg::line_t    ev_line;
  logic                    ev_dirty;

  rsp_exp_t exp_q[$];        // outstanding lookups
  rsp_exp_t exp_head = '0;   // entry of the response on the outputs
  int       err_cnt    = 0;
  int       err_mark   = 0;
  int       pass_tests = 0;
  int       fail_tests = 0;
  int       cycle_cnt  = 0;

  `include "tb_cache_tasks.svh"

  always #2 clk = ~clk; // 4 ns period

  cache_memory_top #(
    .WAYS          ( WAYS       )
  ) i_cache_memory_top (
    .clk_i         ( clk        ),
    .rst_ni        ( rst_n      ),
    .lookup_i      ( lookup     ),
    .lookup_idx_i  ( lookup_idx ),
    .lookup_tag_i  ( lookup_tag ),
    .victim_way_i  ( victim_way ),
    .fill_i        ( fill       ),
    .fill_idx_i    ( fill_idx   ),
    .fill_tag_i    ( fill_tag   ),
    .fill_line_i   ( fill_line  ),
    .fill_dirty_i  ( fill_dirty ),
    .fill_way_i    ( fill_way   ),
    .wr_i          ( wr         ),
    .wr_idx_i      ( wr_idx     ),
    .wr_offs_i     ( wr_offs    ),
    .wr_be_i       ( wr_be      ),
    .wr_data_i     ( wr_data    ),
    .wr_ways_i     ( wr_ways    ),
    .flush_i       ( flush      ),
    .rsp_valid_o   ( rsp_valid  ),
    .hit_o         ( rsp_hit    ),
    .ways_hit_o    ( rsp_ways   ),
    .dirty_o       ( rsp_dirty  ),
    .line_o        ( rsp_line   ),
    .evict_tag_o   ( ev_tag     ),
    .evict_line_o  ( ev_line    ),
    .evict_dirty_o ( ev_dirty   )
  );

  task automatic report_mismatch(input string what, input logic [63:0] got,
                                 input logic [63:0] exp);
    $display("FAILED at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
    err_cnt++;
  endtask

  ////////////////////
  // response checks
  ////////////////////

  // head moves mid cycle, stable for the next edge
  always @(negedge clk)
  begin
    if (rst_n && rsp_valid)
    begin
      if (exp_q.size() == 0)
      begin
        $display("error at %0t ns: response came with no lookup outstanding", $time);
        err_cnt++;
      end
      else
      begin
        exp_head = exp_q.pop_front();
      end
    end
  end

  assert property (@(posedge clk) disable iff (!rst_n) lookup |-> ##2 rsp_valid)
    else begin
      $display("error at %0t ns: no response two cycles after a lookup", $time);
      err_cnt++;
    end
  assert property (@(posedge clk) disable iff (!rst_n) rsp_valid |-> $past(lookup, 2))
    else begin
      $display("error at %0t ns: response without a lookup two cycles before", $time);
      err_cnt++;
    end

  assert property (@(posedge clk) disable iff (!rst_n) rsp_valid |-> rsp_hit == exp_head.hit)
    else report_mismatch("hit_o", $sampled(rsp_hit), $sampled(exp_head.hit));
  assert property (@(posedge clk) disable iff (!rst_n) rsp_valid |-> rsp_ways == exp_head.ways)
    else report_mismatch("ways_hit_o", $sampled(rsp_ways), $sampled(exp_head.ways));
  assert property (@(posedge clk) disable iff (!rst_n)
    rsp_valid |-> rsp_dirty == exp_head.dirty)
    else report_mismatch("dirty_o", $sampled(rsp_dirty), $sampled(exp_head.dirty));
  assert property (@(posedge clk) disable iff (!rst_n)
    rsp_valid && exp_head.hit |-> rsp_line == exp_head.line) // hit line only
    else report_mismatch("line_o", $sampled(rsp_line), $sampled(exp_head.line));
  assert property (@(posedge clk) disable iff (!rst_n)
    rsp_valid |-> ev_dirty == exp_head.ev_dirty)
    else report_mismatch("evict_dirty_o", $sampled(ev_dirty), $sampled(exp_head.ev_dirty));
  assert property (@(posedge clk) disable iff (!rst_n)
    rsp_valid && exp_head.ev_known |-> ev_tag == exp_head.ev_tag)
    else report_mismatch("evict_tag_o", $sampled(ev_tag), $sampled(exp_head.ev_tag));
  assert property (@(posedge clk) disable iff (!rst_n)
    rsp_valid && exp_head.ev_known |-> ev_line == exp_head.ev_line)
    else report_mismatch("evict_line_o", $sampled(ev_line), $sampled(exp_head.ev_line));

  ////////////////////
  // tests
  ////////////////////

  task automatic end_test(input string name);
    drain_rsp();
    if (err_cnt == err_mark)
    begin
      pass_tests++;
      $display("test %s: passed", name);
    end
    else
    begin
      fail_tests++;
      $display("test %s: failed with %0d errors", name, err_cnt - err_mark);
    end
    err_mark = err_cnt;
  endtask

  task automatic test_random();
    int                  op;
    int                  way;
    cache_mem_pkg::idx_t idx;
    cache_mem_pkg::tag_t tag;
    logic [WAYS-1:0]     victim;
    flush_all(); // old directed tags out of the way
    for (int n = 0; n < N_RANDOM; n++)
    begin
      op  = $urandom_range(2);
      way = $urandom_range(WAYS - 1);
      idx = cache_mem_pkg::idx_t'($urandom_range(SETS - 1));
      if (op == 0 || (op == 1 && !m_valid[way][idx]))
      begin
        tag    = cache_mem_pkg::tag_t'($urandom);
        tag[0] = way[0]; // lsb = way, ways never share a tag
        load_line(idx, way, tag, {$urandom, $urandom}, 1'($urandom_range(1)));
      end
      else if (op == 1)
      begin
        write_word(idx, cache_mem_pkg::offs_t'($urandom), cache_mem_pkg::word_be_t'($urandom),
                   $urandom, way);
      end
      else
      begin
        tag = cache_mem_pkg::tag_t'($urandom);
        if ($urandom_range(1) == 1 && m_known[way][idx])
        begin
          tag = m_tag[way][idx]; // aim for a hit half the time
        end
        victim = '0;
        victim[$urandom_range(WAYS - 1)] = 1'b1;
        send_lookup(idx, tag, victim);
      end
    end
  endtask

  initial
  begin
    cache_mem_pkg::tag_t tag_a;
    cache_mem_pkg::tag_t tag_b;
    void'($urandom(32'h80fac09d)); // single seed for the run
    clear_model();
    lookup     = 1'b0;
    fill       = 1'b0;
    wr         = 1'b0;
    flush      = 1'b0;
    lookup_idx = '0;
    lookup_tag = '0;
    victim_way = '0;
    fill_idx   = '0;
    fill_tag   = '0;
    fill_line  = '0;
    fill_dirty = 1'b0;
    fill_way   = '0;
    wr_idx     = '0;
    wr_offs    = '0;
    wr_be      = '0;
    wr_data    = '0;
    wr_ways    = '0;
    rst_n = 1'b0;
    repeat (16) @(posedge clk);
    #0.5;
    rst_n = 1'b1;

    // reset miss, every set
    assert (rsp_valid === 1'b0)
      else begin
        $display("error at %0t ns: rsp_valid_o high after reset", $time);
        err_cnt++;
      end
    for (int s = 0; s < SETS; s++)
    begin
      send_lookup(cache_mem_pkg::idx_t'(s), cache_mem_pkg::tag_t'($urandom), 2'b01 << (s % 2));
    end
    end_test("reset miss");

    tag_a    = cache_mem_pkg::tag_t'($urandom);
    tag_a[0] = 1'b1;
    load_line(5, 1, tag_a, {$urandom, $urandom}, 1'b0);
    send_lookup(5, tag_a, 2'b10);
    send_lookup(5, tag_a ^ 22'h2, 2'b01); // wrong tag
    end_test("fill then hit");

    write_word(5, 1, 4'b0101, $urandom, 1);
    write_word(5, 0, 4'b1000, $urandom, 1);
    send_lookup(5, tag_a, 2'b10); // merged line, dirty way 1
    end_test("byte write merge");

    tag_b    = cache_mem_pkg::tag_t'($urandom);
    tag_b[0] = 1'b0;
    load_line(9, 0, tag_b, {$urandom, $urandom}, 1'b1);
    load_line(9, 1, tag_a, {$urandom, $urandom}, 1'b0);
    send_lookup(9, tag_b, 2'b01);
    send_lookup(9, tag_b, 2'b10);
    send_lookup(9, tag_b ^ 22'h4, 2'b01); // miss, victim still reported
    send_lookup(9, tag_b ^ 22'h4, 2'b10);
    end_test("eviction info");

    flush_all();
    send_lookup(5, tag_a, 2'b10);
    send_lookup(9, tag_b, 2'b01);
    send_lookup(9, tag_a, 2'b10);
    end_test("flush");

    test_random();
    end_test("random traffic");

    $display("tests passed %0d, failed %0d", pass_tests, fail_tests);
    if (fail_tests == 0 && err_cnt == 0)
    begin
      $display("TEST RESULT: PASS");
    end
    else
    begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // watchdog
  always @(posedge clk)
  begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES)
    begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

endmodule

`default_nettype wire
